// ==== files.f ====
verilog/vga_fb_pkg.sv
verilog/vga_sync.sv
verilog/vram_ctrl.sv
verilog/pixel_out.sv
verilog/vga_fb_top.sv
testbench/sram_model.sv
testbench/vga_fb_checker.sv
testbench/tb_vga_fb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the frame buffer testbench with Verilator
set -u
cd "$(dirname "$0")"

verilator --binary --assert -j 0 -Wno-fatal --top-module tb_vga_fb \
	-f files.f --Mdir obj_dir -o sim_vga_fb
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/sim_vga_fb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "TEST PASS"; then
	exit 0
fi
exit 1

// ==== testbench/sram_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module sram_model import vga_fb_pkg::*;
	(
		input sram_ctl_t sram_i,
		inout wire [15:0] dq_io
	);

	logic [15:0] mem [0:(1 << SRAM_AW) - 1];
	logic rd_en;

	assign rd_en = !sram_i.ce_n && !sram_i.oe_n && sram_i.we_n;

	// each lane drives only when its strobe is low
	assign dq_io[7:0] = (rd_en && !sram_i.lb_n) ? mem[sram_i.addr][7:0] : 8'bz;
	assign dq_io[15:8] = (rd_en && !sram_i.ub_n) ? mem[sram_i.addr][15:8] : 8'bz;

	// store once strobe, address and data have settled
	always @(negedge sram_i.we_n)
	begin
		#1;
		if (!sram_i.ce_n && !sram_i.we_n)
		begin
			if (!sram_i.lb_n)
				mem[sram_i.addr][7:0] <= dq_io[7:0];
			if (!sram_i.ub_n)
				mem[sram_i.addr][15:8] <= dq_io[15:8];
		end
	end

endmodule

`default_nettype wire

// ==== testbench/tb_vga_fb.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_vga_fb import vga_fb_pkg::*;
	();

	// small frame, 48 x 22 ticks in all
	localparam int H_DISPLAY = 32;
	localparam int H_FRONT = 4;
	localparam int H_SYNC = 6;
	localparam int H_BACK = 6;
	localparam int V_DISPLAY = 16;
	localparam int V_FRONT = 2;
	localparam int V_SYNC = 2;
	localparam int V_BACK = 2;
	localparam int H_TOTAL = H_DISPLAY + H_FRONT + H_SYNC + H_BACK;
	localparam int V_TOTAL = V_DISPLAY + V_FRONT + V_SYNC + V_BACK;
	localparam int FRAME_TICKS = H_TOTAL * V_TOTAL;
	localparam int FRAME_BYTES = H_DISPLAY * V_DISPLAY;
	localparam int ACCEPT_LIMIT = 16;

	logic clk;
	logic reset;
	cpu_req_t cpu_req;
	cpu_rsp_t cpu_rsp;
	vga_out_t vga_out;
	sram_ctl_t sram_ctl;
	wire [15:0] sram_dq;

	logic [7:0] ref_mem [0:FRAME_BYTES-1];
	int cyc;
	logic video_check_en;
	logic video_pending;
	int video_checked;

	vga_fb_top #(
		.H_DISPLAY(H_DISPLAY),
		.H_FRONT(H_FRONT),
		.H_SYNC(H_SYNC),
		.H_BACK(H_BACK),
		.V_DISPLAY(V_DISPLAY),
		.V_FRONT(V_FRONT),
		.V_SYNC(V_SYNC),
		.V_BACK(V_BACK)
	) vga_fb_top_i (
		.clk(clk),
		.reset(reset),
		.cpu_req_i(cpu_req),
		.cpu_rsp_o(cpu_rsp),
		.vga_o(vga_out),
		.sram_o(sram_ctl),
		.sram_dq_io(sram_dq)
	);

	sram_model sram_model_i (
		.sram_i(sram_ctl),
		.dq_io(sram_dq)
	);

	always #2 clk = ~clk;

	// clocks since reset, every second one is a pixel tick
	always @(posedge clk, posedge reset)
	begin
		if (reset)
			cyc <= 0;
		else
			cyc <= cyc + 1;
	end

	//============================================================
	// reference model
	//============================================================
	// RGB 3-3-2, red in the top bits
	function automatic rgb_t ref_colour(input int x, input int y);
		logic [7:0] pix;
		rgb_t c;
		pix = ref_mem[y * H_DISPLAY + x];
		c.r = pix[7:5];
		c.g = pix[4:2];
		c.b = pix[1:0];
		return c;
	endfunction

	function automatic logic [7:0] ref_readdata(input logic [VRAM_AW-1:0] addr);
		return ref_mem[addr];
	endfunction

	function automatic vga_out_t ref_video(input int idx);
		int x;
		int y;
		vga_out_t v;
		x = idx % H_TOTAL;
		y = idx / H_TOTAL;
		v.hsync = !((x >= H_DISPLAY + H_FRONT) && (x < H_DISPLAY + H_FRONT + H_SYNC));
		v.vsync = !((y >= V_DISPLAY + V_FRONT) && (y < V_DISPLAY + V_FRONT + V_SYNC));
		if ((x < H_DISPLAY) && (y < V_DISPLAY))
			v.rgb = ref_colour(x, y);
		else
			v.rgb = '0;
		return v;
	endfunction

	// output trails the counters by two ticks
	function automatic int shown_pixel();
		if (cyc < 4)
			return -1;
		return (cyc / 2 - 2) % FRAME_TICKS;
	endfunction

	//============================================================
	// compare helpers
	//============================================================
	task automatic abort_run();
		$display("TEST FAIL");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic check_rsp(input cpu_rsp_t got, input cpu_rsp_t exp);
		if (got !== exp)
		begin
			$display("FAIL cpu_rsp_o: got 0x%h, expected 0x%h", got, exp);
			abort_run();
		end
	endtask

	task automatic check_vga(input vga_out_t got, input vga_out_t exp, input int idx);
		if (got !== exp)
		begin
			$display("FAIL vga_o: got 0x%h, expected 0x%h at pixel %0d", got, exp, idx);
			abort_run();
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
			abort_run();
		end
	endtask

	// video compare on every falling edge while enabled
	always @(negedge clk)
	begin
		if (video_check_en)
		begin
			check_vga(vga_out, ref_video(shown_pixel()), shown_pixel());
			video_checked++;
		end
	end

	//============================================================
	// CPU port
	//============================================================
	task automatic wait_accept();
		int guard;
		guard = 0;
		while (cpu_rsp.waitrequest)
		begin
			@(negedge clk);
			guard++;
			if (guard > ACCEPT_LIMIT)
			begin
				$display("waitrequest stayed high, the request was never accepted");
				abort_run();
			end
		end
		// taken at the next rising edge
		@(negedge clk);
		cpu_req.read = 1'b0;
		cpu_req.write = 1'b0;
	endtask

	task automatic cpu_write(input logic [VRAM_AW-1:0] addr, input logic [7:0] data);
		cpu_req.write = 1'b1;
		cpu_req.address = addr;
		cpu_req.writedata = data;
		wait_accept();
		ref_mem[addr] = data;
	endtask

	task automatic cpu_read(input logic [VRAM_AW-1:0] addr);
		int lat;
		cpu_rsp_t exp;
		cpu_req.read = 1'b1;
		cpu_req.address = addr;
		wait_accept();
		// first cycle after the accepting edge
		lat = 1;
		while (!cpu_rsp.readdatavalid)
		begin
			@(negedge clk);
			lat++;
			if (lat > 3)
			begin
				$display("no readdatavalid within 3 cycles for address 0x%h", addr);
				abort_run();
			end
		end
		if (lat < 2)
		begin
			$display("readdatavalid came only %0d cycle after acceptance", lat);
			abort_run();
		end
		exp.readdata = ref_readdata(addr);
		exp.readdatavalid = 1'b1;
		exp.waitrequest = 1'b0;
		check_rsp(cpu_rsp, exp);
	endtask

	task automatic check_video_frame();
		int guard;
		guard = 0;
		// stop one clock before the first pixel of a frame is shown
		while (!((cyc % 2 == 1) && (shown_pixel() == FRAME_TICKS - 1)))
		begin
			@(negedge clk);
			guard++;
			if (guard > 2 * FRAME_TICKS + 8)
			begin
				$display("video output never reached the first pixel of a frame");
				abort_run();
			end
		end
		// enable on the rising edge before the first pixel
		@(posedge clk);
		video_checked = 0;
		video_check_en = 1'b1;
		guard = 0;
		while (video_checked < 2 * FRAME_TICKS)
		begin
			@(posedge clk);
			guard++;
			if (guard > 2 * FRAME_TICKS + 8)
			begin
				$display("video compare stalled before the end of the frame");
				abort_run();
			end
		end
		video_check_en = 1'b0;
		video_pending = 1'b0;
		@(negedge clk);
	endtask

	//============================================================
	// stimulus
	//============================================================
	initial
	begin
		int i;
		logic [VRAM_AW-1:0] a;
		vga_out_t blank;
		void'($urandom(47130));
		clk = 1'b0;
		reset = 1'b1;
		cpu_req = '0;
		video_check_en = 1'b0;
		video_pending = 1'b0;
		video_checked = 0;
		repeat (8) @(negedge clk);

		// outputs while reset is held
		blank.hsync = 1'b1;
		blank.vsync = 1'b1;
		blank.rgb = '0;
		check_flag("cpu_rsp_o.waitrequest", cpu_rsp.waitrequest, 1'b0);
		check_flag("cpu_rsp_o.readdatavalid", cpu_rsp.readdatavalid, 1'b0);
		check_flag("sram_o.we_n", sram_ctl.we_n, 1'b1);
		check_vga(vga_out, blank, -1);
		reset = 1'b0;
		@(negedge clk);

		// whole frame, then random read back
		for (i = 0; i < FRAME_BYTES; i++)
			cpu_write(VRAM_AW'(i), 8'($urandom));
		for (i = 0; i < 40; i++)
			cpu_read(VRAM_AW'($urandom % FRAME_BYTES));

		// neighbouring bytes share one SRAM word
		for (i = 0; i < 8; i++)
		begin
			a = VRAM_AW'(2 * ($urandom % (FRAME_BYTES / 2)));
			cpu_write(a, 8'($urandom));
			cpu_write(a + 1'b1, 8'($urandom));
			cpu_write(a, 8'($urandom));
			cpu_read(a);
			cpu_read(a + 1'b1);
		end

		// quiet frame
		video_pending = 1'b1;
		check_video_frame();

		// frame with reads running alongside
		video_pending = 1'b1;
		fork
			check_video_frame();
			begin
				while (video_pending)
				begin
					cpu_read(VRAM_AW'($urandom % FRAME_BYTES));
					repeat ($urandom % 3) @(negedge clk);
				end
			end
		join

		$display("TEST PASS");
		$finish;
	end

endmodule

`default_nettype wire

// ==== testbench/vga_fb_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module vga_fb_checker import vga_fb_pkg::*;
	(
		input wire clk,
		input wire reset,
		input sram_ctl_t sram_i,
		input cpu_rsp_t rsp_i
	);

	// write strobe is a single clock pulse
	we_single_cycle: assert property (@(posedge clk) disable iff (reset)
		!sram_i.we_n |=> sram_i.we_n)
	else
		$error("we_n held low for more than one cycle");

	// back in idle once a read returns or the write strobe ends
	idle_no_wait: assert property (@(posedge clk) disable iff (reset)
		(rsp_i.readdatavalid || $rose(sram_i.we_n)) |-> !rsp_i.waitrequest)
	else
		$error("waitrequest still high after the access finished");

	valid_single_pulse: assert property (@(posedge clk) disable iff (reset)
		rsp_i.readdatavalid |=> !rsp_i.readdatavalid)
	else
		$error("readdatavalid high on two cycles in a row");

endmodule

bind vram_ctrl vga_fb_checker vga_fb_checker_i (
	.clk(clk),
	.reset(reset),
	.sram_i(sram_o),
	.rsp_i(cpu_rsp_o)
);

`default_nettype wire

// ==== verilog/pixel_out.sv ====
`timescale 1ns/1ps
`default_nettype none

module pixel_out import vga_fb_pkg::*;
	(
		input wire clk,
		input wire reset,
		input sync_t sync_i,
		input wire [7:0] vga_data_i,
		output vga_out_t vga_o
	);

	// {hsync, vsync, video_on} in stage1, {hsync, vsync} in stage2
	logic [2:0] stage1_reg;
	logic [1:0] stage2_reg;
	rgb_t rgb_reg;

	//============================================================
	// two tick delay of sync and enable
	//============================================================
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			// syncs idle high, display off
			stage1_reg <= 3'b110;
			stage2_reg <= 2'b11;
		end
		else if (sync_i.p_tick)
		begin
			stage1_reg <= {sync_i.hsync, sync_i.vsync, sync_i.video_on};
			stage2_reg <= stage1_reg[2:1];
		end
	end

	// fetched byte lines up with stage1
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			rgb_reg <= '0;
		else if (sync_i.p_tick)
		begin
			if (stage1_reg[0])
				rgb_reg <= rgb_t'(vga_data_i);
			else
				rgb_reg <= '0;
		end
	end

	always_comb
	begin
		vga_o.hsync = stage2_reg[1];
		vga_o.vsync = stage2_reg[0];
		vga_o.rgb = rgb_reg;
	end

endmodule

`default_nettype wire

// ==== verilog/vga_fb_pkg.sv ====
`default_nettype none

package vga_fb_pkg;

	// byte address into video RAM, word address on the SRAM pins
	localparam int VRAM_AW = 19;
	localparam int SRAM_AW = 18;
	localparam int COORD_W = 10;

	typedef struct packed {
		logic [COORD_W-1:0] x;
		logic [COORD_W-1:0] y;
	} pixel_pos_t;

	// sync pulses are active low
	typedef struct packed {
		logic hsync;
		logic vsync;
		logic video_on;
		logic p_tick;
	} sync_t;

	//============================================================
	// CPU port
	//============================================================
	typedef struct packed {
		logic               read;
		logic               write;
		logic [VRAM_AW-1:0] address;
		logic [7:0]         writedata;
	} cpu_req_t;

	typedef struct packed {
		logic [7:0] readdata;
		logic       readdatavalid;
		logic       waitrequest;
	} cpu_rsp_t;

	//============================================================
	// SRAM pins, all strobes active low
	//============================================================
	typedef struct packed {
		logic [SRAM_AW-1:0] addr;
		logic               ub_n;
		logic               lb_n;
		logic               ce_n;
		logic               oe_n;
		logic               we_n;
	} sram_ctl_t;

	// RGB 3-3-2, red in the top bits
	typedef struct packed {
		logic [2:0] r;
		logic [2:0] g;
		logic [1:0] b;
	} rgb_t;

	typedef struct packed {
		logic hsync;
		logic vsync;
		rgb_t rgb;
	} vga_out_t;

endpackage

`default_nettype wire

// ==== verilog/vga_fb_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module vga_fb_top import vga_fb_pkg::*;
	#(
		parameter int H_DISPLAY = 640,
		parameter int H_FRONT = 16,
		parameter int H_SYNC = 96,
		parameter int H_BACK = 48,
		parameter int V_DISPLAY = 480,
		parameter int V_FRONT = 10,
		parameter int V_SYNC = 2,
		parameter int V_BACK = 33
	)
	(
		input wire clk,
		input wire reset,
		input cpu_req_t cpu_req_i,
		output cpu_rsp_t cpu_rsp_o,
		output vga_out_t vga_o,
		output sram_ctl_t sram_o,
		inout wire [15:0] sram_dq_io
	);

	pixel_pos_t pos;
	sync_t sync;
	logic [7:0] vga_data;

	//============================================================
	// timing
	//============================================================
	vga_sync #(
		.H_DISPLAY(H_DISPLAY),
		.H_FRONT(H_FRONT),
		.H_SYNC(H_SYNC),
		.H_BACK(H_BACK),
		.V_DISPLAY(V_DISPLAY),
		.V_FRONT(V_FRONT),
		.V_SYNC(V_SYNC),
		.V_BACK(V_BACK)
	) vga_sync_i (
		.clk(clk),
		.reset(reset),
		.pos_o(pos),
		.sync_o(sync)
	);

	// SRAM shared by video fetch and CPU
	vram_ctrl #(
		.H_DISPLAY(H_DISPLAY)
	) vram_ctrl_i (
		.clk(clk),
		.reset(reset),
		.pos_i(pos),
		.p_tick_i(sync.p_tick),
		.cpu_req_i(cpu_req_i),
		.cpu_rsp_o(cpu_rsp_o),
		.sram_o(sram_o),
		.sram_dq_io(sram_dq_io),
		.vga_data_o(vga_data)
	);

	pixel_out pixel_out_i (
		.clk(clk),
		.reset(reset),
		.sync_i(sync),
		.vga_data_i(vga_data),
		.vga_o(vga_o)
	);

endmodule

`default_nettype wire

// ==== verilog/vga_sync.sv ====
`timescale 1ns/1ps
`default_nettype none

module vga_sync import vga_fb_pkg::*;
	#(
		parameter int H_DISPLAY = 640,
		parameter int H_FRONT = 16,
		parameter int H_SYNC = 96,
		parameter int H_BACK = 48,
		parameter int V_DISPLAY = 480,
		parameter int V_FRONT = 10,
		parameter int V_SYNC = 2,
		parameter int V_BACK = 33
	)
	(
		input wire clk,
		input wire reset,
		output pixel_pos_t pos_o,
		output sync_t sync_o
	);

	// totals and sync pulse boundaries
	localparam int H_TOTAL = H_DISPLAY + H_FRONT + H_SYNC + H_BACK;
	localparam int V_TOTAL = V_DISPLAY + V_FRONT + V_SYNC + V_BACK;
	localparam int H_SYNC_START = H_DISPLAY + H_FRONT;
	localparam int H_SYNC_END = H_SYNC_START + H_SYNC - 1;
	localparam int V_SYNC_START = V_DISPLAY + V_FRONT;
	localparam int V_SYNC_END = V_SYNC_START + V_SYNC - 1;

	logic tick_reg;
	logic [COORD_W-1:0] h_count_reg;
	logic [COORD_W-1:0] v_count_reg;
	logic h_end;
	logic v_end;

	//============================================================
	// pixel tick, one clock in two
	//============================================================
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			tick_reg <= 1'b0;
		else
			tick_reg <= ~tick_reg;
	end

	assign h_end = (h_count_reg == COORD_W'(H_TOTAL - 1));
	assign v_end = (v_count_reg == COORD_W'(V_TOTAL - 1));

	//============================================================
	// counters
	//============================================================
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			h_count_reg <= '0;
			v_count_reg <= '0;
		end
		else if (tick_reg)
		begin
			if (h_end)
			begin
				h_count_reg <= '0;
				// vertical steps once per line
				if (v_end)
					v_count_reg <= '0;
				else
					v_count_reg <= v_count_reg + 1'b1;
			end
			else
			begin
				h_count_reg <= h_count_reg + 1'b1;
			end
		end
	end

	// sync and enable decoded straight from the counters
	always_comb
	begin
		pos_o.x = h_count_reg;
		pos_o.y = v_count_reg;
		sync_o.hsync = ~((h_count_reg >= COORD_W'(H_SYNC_START)) &&
			(h_count_reg <= COORD_W'(H_SYNC_END)));
		sync_o.vsync = ~((v_count_reg >= COORD_W'(V_SYNC_START)) &&
			(v_count_reg <= COORD_W'(V_SYNC_END)));
		sync_o.video_on = (h_count_reg < COORD_W'(H_DISPLAY)) &&
			(v_count_reg < COORD_W'(V_DISPLAY));
		sync_o.p_tick = tick_reg;
	end

endmodule

`default_nettype wire

// ==== verilog/vram_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module vram_ctrl import vga_fb_pkg::*;
	#(
		parameter int H_DISPLAY = 640
	)
	(
		input wire clk,
		input wire reset,

		// from the sync generator
		input pixel_pos_t pos_i,
		input wire p_tick_i,

		// CPU port
		input cpu_req_t cpu_req_i,
		output cpu_rsp_t cpu_rsp_o,

		// SRAM pins
		output sram_ctl_t sram_o,
		inout wire [15:0] sram_dq_io,

		// byte for the pixel stage
		output logic [7:0] vga_data_o
	);

	localparam logic [2:0]
		idle = 3'b000,
		wait_rd = 3'b001,
		rd = 3'b010,
		wait_wr = 3'b100,
		wr = 3'b101;

	logic [2:0] state_reg;
	logic [2:0] state_next;
	logic rd_valid_reg;
	logic rd_valid_next;
	logic we_n_reg;
	logic we_n_next;

	logic [VRAM_AW-1:0] cpu_addr_reg;
	logic [VRAM_AW-1:0] cpu_addr_next;
	logic [VRAM_AW-1:0] mem_addr_reg;
	logic [VRAM_AW-1:0] mem_addr_next;
	logic [7:0] cpu_wr_data_reg;
	logic [7:0] cpu_wr_data_next;
	logic [7:0] cpu_rd_data_reg;
	logic [7:0] cpu_rd_data_next;
	logic [7:0] vga_rd_data_reg;

	logic [VRAM_AW-1:0] vga_addr;
	logic [7:0] byte_from_sram;

	// linear frame address of the current pixel
	assign vga_addr = VRAM_AW'(pos_i.y) * VRAM_AW'(H_DISPLAY) + VRAM_AW'(pos_i.x);

	// odd bytes sit in the upper lane
	assign byte_from_sram = mem_addr_reg[0] ? sram_dq_io[15:8] : sram_dq_io[7:0];

	//============================================================
	// video port
	//============================================================
	// tick cycles always see the video address
	always_ff @(posedge clk)
	begin
		if (p_tick_i)
			vga_rd_data_reg <= byte_from_sram;
	end

	assign vga_data_o = vga_rd_data_reg;

	//============================================================
	// FSMD registers
	//============================================================
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			state_reg <= idle;
			rd_valid_reg <= 1'b0;
			we_n_reg <= 1'b1;
		end
		else
		begin
			state_reg <= state_next;
			rd_valid_reg <= rd_valid_next;
			we_n_reg <= we_n_next;
		end
	end

	always_ff @(posedge clk)
	begin
		cpu_addr_reg <= cpu_addr_next;
		cpu_wr_data_reg <= cpu_wr_data_next;
		cpu_rd_data_reg <= cpu_rd_data_next;
		mem_addr_reg <= mem_addr_next;
	end

	// CPU access only lands in the cycle between ticks
	always_comb
	begin
		state_next = state_reg;
		cpu_addr_next = cpu_addr_reg;
		cpu_wr_data_next = cpu_wr_data_reg;
		cpu_rd_data_next = cpu_rd_data_reg;
		mem_addr_next = vga_addr;
		rd_valid_next = 1'b0;
		we_n_next = 1'b1;

		case (state_reg)
			idle:
			begin
				if (cpu_req_i.read)
				begin
					cpu_addr_next = cpu_req_i.address;
					if (p_tick_i)
					begin
						state_next = rd;
						mem_addr_next = cpu_req_i.address;
					end
					else
						state_next = wait_rd;
				end
				else if (cpu_req_i.write)
				begin
					cpu_addr_next = cpu_req_i.address;
					cpu_wr_data_next = cpu_req_i.writedata;
					if (p_tick_i)
					begin
						state_next = wr;
						mem_addr_next = cpu_req_i.address;
						we_n_next = 1'b0;
					end
					else
						state_next = wait_wr;
				end
			end
			// tick cycle passes, then the CPU slot
			wait_rd:
			begin
				state_next = rd;
				mem_addr_next = cpu_addr_reg;
			end
			rd:
			begin
				state_next = idle;
				cpu_rd_data_next = byte_from_sram;
				rd_valid_next = 1'b1;
			end
			wait_wr:
			begin
				state_next = wr;
				mem_addr_next = cpu_addr_reg;
				we_n_next = 1'b0;
			end
			wr:
				state_next = idle;
			default:
				state_next = idle;
		endcase
	end

	always_comb
	begin
		cpu_rsp_o.readdata = cpu_rd_data_reg;
		cpu_rsp_o.readdatavalid = rd_valid_reg;
		cpu_rsp_o.waitrequest = (state_reg != idle);
	end

	//============================================================
	// SRAM pins, 512K x 8 view of a 256K x 16 part
	//============================================================
	always_comb
	begin
		sram_o.addr = mem_addr_reg[VRAM_AW-1:1];
		sram_o.lb_n = mem_addr_reg[0];
		sram_o.ub_n = ~mem_addr_reg[0];
		sram_o.ce_n = 1'b0;
		// output enable dropped while writing
		sram_o.oe_n = ~we_n_reg;
		sram_o.we_n = we_n_reg;
	end

	// same byte on both halves, lane strobe picks one
	assign sram_dq_io = we_n_reg ? 16'bz : {cpu_wr_data_reg, cpu_wr_data_reg};

endmodule

`default_nettype wire
